// File: Bender.yml
package:
  name: mycpu

sources:
  - mycpu_pkg.sv
  - if_stage.sv
  - regfile.sv
  - id_stage.sv
  - exe_stage.sv
  - mem_stage.sv
  - wb_stage.sv
  - mycpu_top.sv
  - target: test
    files:
      - mycpu_checker.sv
      - tb_mycpu.sv

// File: build.f
mycpu_pkg.sv
if_stage.sv
regfile.sv
id_stage.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
mycpu_top.sv
mycpu_checker.sv
tb_mycpu.sv

// File: exe_stage.sv
`default_nettype none

module exe_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       id_valid,
    input  mycpu_pkg::id_exe_t         id_exe,
    input  logic                       mem_allowin,
    output logic                       exe_allowin,
    output logic                       exe_valid,
    output mycpu_pkg::exe_mem_t        exe_mem,
    output mycpu_pkg::dest_t           exe_dest,
    output logic                       data_sram_en,
    output logic [3:0]                 data_sram_wen,
    output logic [mycpu_pkg::XLEN-1:0] data_sram_addr,
    output logic [mycpu_pkg::XLEN-1:0] data_sram_wdata
);

    mycpu_pkg::id_exe_t         id_exe_r;
    logic [mycpu_pkg::XLEN-1:0] result;

    // single-cycle stage, always ready to go
    assign exe_allowin = !exe_valid || mem_allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && exe_allowin) begin
            id_exe_r <= id_exe;
        end
    end

    // alu
    always_comb begin
        case (id_exe_r.alu_op)
            mycpu_pkg::ALU_ADD: result = id_exe_r.src1 + id_exe_r.src2;
            mycpu_pkg::ALU_SUB: result = id_exe_r.src1 - id_exe_r.src2;
            mycpu_pkg::ALU_AND: result = id_exe_r.src1 & id_exe_r.src2;
            mycpu_pkg::ALU_OR:  result = id_exe_r.src1 | id_exe_r.src2;
            mycpu_pkg::ALU_XOR: result = id_exe_r.src1 ^ id_exe_r.src2;
            mycpu_pkg::ALU_SLT: begin
                result    = '0;
                result[0] = $signed(id_exe_r.src1) < $signed(id_exe_r.src2);
            end
            mycpu_pkg::ALU_LUI: result = {id_exe_r.src2[15:0], 16'h0};
            default:            result = '0;
        endcase
    end

    // request goes out as the item leaves, data is back in mem_stage
    assign data_sram_en    = exe_valid && mem_allowin && (id_exe_r.load || id_exe_r.store);
    assign data_sram_wen   = (exe_valid && mem_allowin && id_exe_r.store) ? 4'hf : 4'h0;
    assign data_sram_addr  = result;
    assign data_sram_wdata = id_exe_r.st_data;

    assign exe_mem = '{
        pc:     id_exe_r.pc,
        result: result,
        load:   id_exe_r.load,
        rf_we:  id_exe_r.rf_we,
        dest:   id_exe_r.dest
    };

    assign exe_dest = '{we: exe_valid && id_exe_r.rf_we, num: id_exe_r.dest};

endmodule

`default_nettype wire

// File: id_stage.sv
`default_nettype none

module id_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         if_valid,
    input  mycpu_pkg::if_id_t            if_id,
    input  logic                         exe_allowin,
    input  mycpu_pkg::dest_t             exe_dest,
    input  mycpu_pkg::dest_t             mem_dest,
    input  mycpu_pkg::dest_t             wb_dest,
    input  logic [mycpu_pkg::XLEN-1:0]   rdata1,
    input  logic [mycpu_pkg::XLEN-1:0]   rdata2,
    output logic                         id_allowin,
    output logic                         id_valid,
    output mycpu_pkg::id_exe_t           id_exe,
    output logic [mycpu_pkg::REG_AW-1:0] raddr1,
    output logic [mycpu_pkg::REG_AW-1:0] raddr2,
    output logic                         br_taken,
    output logic [mycpu_pkg::XLEN-1:0]   br_target
);

    logic               valid;
    logic               ready_go;
    mycpu_pkg::if_id_t  if_id_r;

    mycpu_pkg::opcode_e opcode;
    mycpu_pkg::funct_e  funct;
    logic [4:0]         rs;
    logic [4:0]         rt;
    logic [4:0]         rd;
    logic [15:0]        imm;
    logic [31:0]        sext_imm;

    mycpu_pkg::alu_op_e alu_op;
    logic               use_imm;
    logic               zero_ext;
    logic               rf_we;
    logic               dest_rt;
    logic               load;
    logic               store;
    logic               is_beq;
    logic               is_bne;
    logic               use_rs;
    logic               use_rt;
    logic               hazard;
    logic [4:0]         dest;

    // ------------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------------

    assign ready_go   = !hazard;
    assign id_allowin = !valid || (ready_go && exe_allowin);
    assign id_valid   = valid && ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (id_allowin) begin
            valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            if_id_r <= if_id;
        end
    end

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------

    assign opcode   = mycpu_pkg::opcode_e'(if_id_r.inst[31:26]);
    assign funct    = mycpu_pkg::funct_e'(if_id_r.inst[5:0]);
    assign rs       = if_id_r.inst[25:21];
    assign rt       = if_id_r.inst[20:16];
    assign rd       = if_id_r.inst[15:11];
    assign imm      = if_id_r.inst[15:0];
    assign sext_imm = {{16{imm[15]}}, imm};

    // anything not listed falls out as a no-op
    always_comb begin
        alu_op   = mycpu_pkg::ALU_ADD;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        rf_we    = 1'b0;
        dest_rt  = 1'b1;
        load     = 1'b0;
        store    = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        use_rs   = 1'b1;
        use_rt   = 1'b0;
        case (opcode)
            mycpu_pkg::OP_SPECIAL: begin
                use_imm = 1'b0;
                dest_rt = 1'b0;
                use_rt  = 1'b1;
                rf_we   = 1'b1;
                case (funct)
                    mycpu_pkg::FN_ADDU: alu_op = mycpu_pkg::ALU_ADD;
                    mycpu_pkg::FN_SUBU: alu_op = mycpu_pkg::ALU_SUB;
                    mycpu_pkg::FN_AND:  alu_op = mycpu_pkg::ALU_AND;
                    mycpu_pkg::FN_OR:   alu_op = mycpu_pkg::ALU_OR;
                    mycpu_pkg::FN_XOR:  alu_op = mycpu_pkg::ALU_XOR;
                    mycpu_pkg::FN_SLT:  alu_op = mycpu_pkg::ALU_SLT;
                    default: begin
                        rf_we  = 1'b0;
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                    end
                endcase
            end
            mycpu_pkg::OP_ADDIU: rf_we = 1'b1;
            mycpu_pkg::OP_ORI: begin
                alu_op   = mycpu_pkg::ALU_OR;
                zero_ext = 1'b1;
                rf_we    = 1'b1;
            end
            mycpu_pkg::OP_LUI: begin
                alu_op = mycpu_pkg::ALU_LUI;
                rf_we  = 1'b1;
                use_rs = 1'b0;
            end
            mycpu_pkg::OP_LW: begin
                load  = 1'b1;
                rf_we = 1'b1;
            end
            mycpu_pkg::OP_SW: begin
                store  = 1'b1;
                use_rt = 1'b1;
            end
            mycpu_pkg::OP_BEQ: begin
                is_beq = 1'b1;
                use_rt = 1'b1;
            end
            mycpu_pkg::OP_BNE: begin
                is_bne = 1'b1;
                use_rt = 1'b1;
            end
            default: use_rs = 1'b0;
        endcase
    end

    assign dest   = dest_rt ? rt : rd;
    assign raddr1 = rs;
    assign raddr2 = rt;

    // ------------------------------------------------------------------------
    // interlock, no forwarding
    // ------------------------------------------------------------------------

    function automatic logic pending(input logic [4:0] r, input mycpu_pkg::dest_t e,
                                     input mycpu_pkg::dest_t m, input mycpu_pkg::dest_t w);
        return (r != 5'd0) && ((e.we && e.num == r) || (m.we && m.num == r) ||
                               (w.we && w.num == r));
    endfunction

    assign hazard = (use_rs && pending(rs, exe_dest, mem_dest, wb_dest)) ||
                    (use_rt && pending(rt, exe_dest, mem_dest, wb_dest));

    // branch resolved here, target relative to the delay slot
    assign br_target = if_id_r.pc + 32'd4 + {sext_imm[29:0], 2'b00};
    assign br_taken  = valid && ready_go &&
                       ((is_beq && rdata1 == rdata2) || (is_bne && rdata1 != rdata2));

    // writes to $0 are dropped here so nothing retires with dest 0
    assign id_exe = '{
        pc:      if_id_r.pc,
        alu_op:  alu_op,
        src1:    rdata1,
        src2:    use_imm ? (zero_ext ? {16'h0, imm} : sext_imm) : rdata2,
        st_data: rdata2,
        load:    load,
        store:   store,
        rf_we:   rf_we && (dest != 5'd0),
        dest:    dest
    };

endmodule

`default_nettype wire

// File: if_stage.sv
`default_nettype none

module if_stage #(
    parameter logic [mycpu_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       id_allowin,
    input  logic                       br_taken,
    input  logic [mycpu_pkg::XLEN-1:0] br_target,
    input  logic [mycpu_pkg::XLEN-1:0] inst_sram_rdata,
    output logic                       if_valid,
    output mycpu_pkg::if_id_t          if_id,
    output logic                       inst_sram_en,
    output logic [mycpu_pkg::XLEN-1:0] inst_sram_addr
);

    // pc of the word currently returned by the instruction SRAM
    logic [mycpu_pkg::XLEN-1:0] fetch_pc;

    // a new fetch is issued whenever decode takes the current item
    assign inst_sram_en   = id_allowin;
    assign inst_sram_addr = br_taken ? br_target : fetch_pc + 32'd4;

    // starts one word below the reset vector so the first request hits it
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= RESET_PC - 32'd4;
            if_valid <= 1'b0;
        end else if (inst_sram_en) begin
            fetch_pc <= inst_sram_addr;
            if_valid <= 1'b1;
        end
    end

    // SRAM holds rdata while en is low, so a stalled item stays intact
    assign if_id = '{pc: fetch_pc, inst: inst_sram_rdata};

endmodule

`default_nettype wire

// File: mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       exe_valid,
    input  mycpu_pkg::exe_mem_t        exe_mem,
    input  logic                       wb_allowin,
    input  logic [mycpu_pkg::XLEN-1:0] data_sram_rdata,
    output logic                       mem_allowin,
    output logic                       mem_valid,
    output mycpu_pkg::mem_wb_t         mem_wb,
    output mycpu_pkg::dest_t           mem_dest
);

    mycpu_pkg::exe_mem_t exe_mem_r;

    assign mem_allowin = !mem_valid || wb_allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && mem_allowin) begin
            exe_mem_r <= exe_mem;
        end
    end

    // load word arrives from the SRAM in this cycle
    assign mem_wb = '{
        pc:    exe_mem_r.pc,
        wdata: exe_mem_r.load ? data_sram_rdata : exe_mem_r.result,
        rf_we: exe_mem_r.rf_we,
        dest:  exe_mem_r.dest
    };

    assign mem_dest = '{we: mem_valid && exe_mem_r.rf_we, num: exe_mem_r.dest};

endmodule

`default_nettype wire

// File: mycpu_checker.sv
`default_nettype none

module mycpu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] inst_sram_addr,
    input  logic        data_sram_en,
    input  logic [3:0]  data_sram_wen,
    input  logic [3:0]  debug_wb_rf_wen,
    input  logic [4:0]  debug_wb_rf_wnum
);

    // number of assertion failures so far
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // port rules
    // ------------------------------------------------------------------------

    wen_full_or_none: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
    else begin
        $error("debug write enable is neither zero nor all ones");
        fail_count++;
    end

    // byte enables only together with a request
    wen_needs_en: assert property (@(posedge clk) disable iff (rst)
        data_sram_wen != 4'h0 |-> data_sram_en)
    else begin
        $error("data SRAM write enable without request");
        fail_count++;
    end

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_sram_addr[1:0] == 2'b00)
    else begin
        $error("instruction fetch address is not word aligned");
        fail_count++;
    end

    no_write_to_zero: assert property (@(posedge clk) disable iff (rst)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
    else begin
        $error("retired write targets register 0");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: mycpu_pkg.sv
`default_nettype none

package mycpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ------------------------------------------------------------------------
    // instruction field encodings
    // ------------------------------------------------------------------------

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // ------------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
        logic [XLEN-1:0]   st_data;
        logic              load;
        logic              store;
        logic              rf_we;
        logic [REG_AW-1:0] dest;
    } id_exe_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   result;
        logic              load;
        logic              rf_we;
        logic [REG_AW-1:0] dest;
    } exe_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   wdata;
        logic              rf_we;
        logic [REG_AW-1:0] dest;
    } mem_wb_t;

    // register file write, also shown on the debug port
    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] num;
        logic [XLEN-1:0]   data;
    } rf_write_t;

    // pending register write of a later stage, seen by the interlock
    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] num;
    } dest_t;

endpackage

`default_nettype wire

// File: mycpu_top.sv
`default_nettype none

module mycpu_top #(
    parameter logic [mycpu_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        rst,
    // instruction SRAM
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data SRAM
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // retired register writes
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic                         if_valid;
    logic                         id_valid;
    logic                         exe_valid;
    logic                         mem_valid;
    logic                         id_allowin;
    logic                         exe_allowin;
    logic                         mem_allowin;
    logic                         wb_allowin;
    logic                         br_taken;
    logic [31:0]                  br_target;
    logic [4:0]                   raddr1;
    logic [4:0]                   raddr2;
    logic [31:0]                  rdata1;
    logic [31:0]                  rdata2;
    mycpu_pkg::if_id_t            if_id;
    mycpu_pkg::id_exe_t           id_exe;
    mycpu_pkg::exe_mem_t          exe_mem;
    mycpu_pkg::mem_wb_t           mem_wb;
    mycpu_pkg::rf_write_t         rf_wr;
    mycpu_pkg::dest_t             exe_dest;
    mycpu_pkg::dest_t             mem_dest;
    mycpu_pkg::dest_t             wb_dest;

    // instruction memory is read only
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = 32'h0;

    if_stage #(
        .RESET_PC (RESET_PC)
    ) u_if_stage (
        .clk             (clk),
        .rst             (rst),
        .id_allowin      (id_allowin),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .inst_sram_rdata (inst_sram_rdata),
        .if_valid        (if_valid),
        .if_id           (if_id),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr)
    );

    id_stage u_id_stage (
        .clk         (clk),
        .rst         (rst),
        .if_valid    (if_valid),
        .if_id       (if_id),
        .exe_allowin (exe_allowin),
        .exe_dest    (exe_dest),
        .mem_dest    (mem_dest),
        .wb_dest     (wb_dest),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .id_allowin  (id_allowin),
        .id_valid    (id_valid),
        .id_exe      (id_exe),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wr     (rf_wr),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exe_stage u_exe_stage (
        .clk             (clk),
        .rst             (rst),
        .id_valid        (id_valid),
        .id_exe          (id_exe),
        .mem_allowin     (mem_allowin),
        .exe_allowin     (exe_allowin),
        .exe_valid       (exe_valid),
        .exe_mem         (exe_mem),
        .exe_dest        (exe_dest),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .rst             (rst),
        .exe_valid       (exe_valid),
        .exe_mem         (exe_mem),
        .wb_allowin      (wb_allowin),
        .data_sram_rdata (data_sram_rdata),
        .mem_allowin     (mem_allowin),
        .mem_valid       (mem_valid),
        .mem_wb          (mem_wb),
        .mem_dest        (mem_dest)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .rst               (rst),
        .mem_valid         (mem_valid),
        .mem_wb            (mem_wb),
        .wb_allowin        (wb_allowin),
        .rf_wr             (rf_wr),
        .wb_dest           (wb_dest),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile (
    input  logic                         clk,
    input  logic [mycpu_pkg::REG_AW-1:0] raddr1,
    input  logic [mycpu_pkg::REG_AW-1:0] raddr2,
    input  mycpu_pkg::rf_write_t         wr,
    output logic [mycpu_pkg::XLEN-1:0]   rdata1,
    output logic [mycpu_pkg::XLEN-1:0]   rdata2
);

    // $0 has no storage
    logic [mycpu_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr.we && wr.num != '0) begin
            regs[wr.num] <= wr.data;
        end
    end

    // combinational read, no write-through
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: tb_mycpu.sv
`default_nettype none

module tb_mycpu;

    localparam logic [31:0] RESET_PC     = 32'hbfc0_0000;
    localparam int          N_ENTRIES    = 26;
    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 16;
    localparam int          MEM_AW       = 8;
    localparam int          MEM_WORDS    = 1 << MEM_AW;
    localparam logic [31:0] DATA_ADDR    = 32'h0000_0040;
    localparam logic [31:0] SEED         = 32'h3da4;

    // MIPS32 field encodings
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    // one program line and the write it must retire
    typedef struct packed {
        logic [31:0] inst;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] value;
    } entry_t;

    logic        clk;
    logic        rst = 1'b1;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata = '0;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = '0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    entry_t      prog [N_ENTRIES];
    int          n_entries = 0;
    int          dmem_writes = 0;
    logic [31:0] last_wr_addr = '0;
    logic [3:0]  last_wr_wen = '0;

    mycpu_top #(
        .RESET_PC (RESET_PC)
    ) u_mycpu_top (
        .clk               (clk),
        .rst               (rst),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind mycpu_top mycpu_checker u_checker (
        .clk              (clk),
        .rst              (rst),
        .inst_sram_addr   (inst_sram_addr),
        .data_sram_en     (data_sram_en),
        .data_sram_wen    (data_sram_wen),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // SRAM models with one cycle of read latency
    // ------------------------------------------------------------------------

    // rdata holds while en is low
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[MEM_AW+1:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[MEM_AW+1:2]];
            if (data_sram_wen != 4'h0) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_sram_wen[b]) begin
                        dmem[data_sram_addr[MEM_AW+1:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                    end
                end
                dmem_writes  <= dmem_writes + 1;
                last_wr_addr <= data_sram_addr;
                last_wr_wen  <= data_sram_wen;
            end
        end
    end

    // instruction port never writes
    always @(negedge clk) begin
        check_value("instruction SRAM write enable", 32'(inst_sram_wen), 32'h0);
        check_value("instruction SRAM write data", inst_sram_wdata, 32'h0);
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_entry(input logic [31:0] inst, input logic we, input logic [4:0] dest,
                             input logic [31:0] value);
        prog[n_entries] = '{inst: inst, we: we, dest: dest, value: value};
        n_entries++;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // program with hand-computed results
    // r1 stays 0x12345678 from the second line on
    task automatic build_program();
        add_entry(i_type(OP_LUI, 0, 1, 16'h1234), 1, 1, 32'h1234_0000);
        add_entry(i_type(OP_ORI, 1, 1, 16'h5678), 1, 1, 32'h1234_5678);
        add_entry(i_type(OP_ADDIU, 0, 2, 16'hffff), 1, 2, 32'hffff_ffff);
        add_entry(i_type(OP_ADDIU, 0, 3, 16'h0100), 1, 3, 32'h0000_0100);
        // r3 at distance one and r1 at distance three
        add_entry(r_type(FN_ADDU, 1, 3, 4), 1, 4, 32'h1234_5778);
        add_entry(r_type(FN_SUBU, 3, 1, 5), 1, 5, 32'hedcb_aa88);
        add_entry(r_type(FN_AND, 1, 2, 6), 1, 6, 32'h1234_5678);
        // r5 at distance two
        add_entry(r_type(FN_OR, 3, 5, 7), 1, 7, 32'hedcb_ab88);
        add_entry(r_type(FN_XOR, 1, 2, 8), 1, 8, 32'hedcb_a987);
        add_entry(r_type(FN_SLT, 2, 3, 9), 1, 9, 32'h0000_0001);
        add_entry(r_type(FN_SLT, 3, 2, 10), 1, 10, 32'h0000_0000);
        add_entry(i_type(OP_ADDIU, 0, 11, DATA_ADDR[15:0]), 1, 11, DATA_ADDR);
        add_entry(i_type(OP_SW, 11, 1, 16'h0000), 0, 0, 32'h0);
        add_entry(i_type(OP_LW, 11, 12, 16'h0000), 1, 12, 32'h1234_5678);
        add_entry(r_type(FN_ADDU, 12, 12, 13), 1, 13, 32'h2468_acf0);
        // taken beq runs its slot and skips the next line
        add_entry(i_type(OP_BEQ, 10, 0, 16'd2), 0, 0, 32'h0);
        add_entry(i_type(OP_ADDIU, 0, 14, 16'h0007), 1, 14, 32'h0000_0007);
        add_entry(i_type(OP_ADDIU, 0, 15, 16'h0055), 0, 0, 32'h0);
        add_entry(i_type(OP_BNE, 9, 10, 16'd2), 0, 0, 32'h0);
        add_entry(i_type(OP_ORI, 0, 16, 16'h00ff), 1, 16, 32'h0000_00ff);
        add_entry(i_type(OP_ADDIU, 0, 15, 16'h0066), 0, 0, 32'h0);
        // not taken so it falls through
        add_entry(i_type(OP_BEQ, 9, 10, 16'd2), 0, 0, 32'h0);
        add_entry(i_type(OP_ADDIU, 0, 17, 16'h0011), 1, 17, 32'h0000_0011);
        add_entry(i_type(OP_ADDIU, 0, 18, 16'h0022), 1, 18, 32'h0000_0022);
        add_entry(r_type(FN_ADDU, 14, 16, 19), 1, 19, 32'h0000_0106);
        add_entry(r_type(FN_SUBU, 18, 17, 20), 1, 20, 32'h0000_0011);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] word_addr;

        void'($urandom(SEED));
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0;
            dmem[i] = $urandom();
        end
        for (int k = 0; k < n_entries; k++) begin
            word_addr = (RESET_PC + 32'(4 * k)) >> 2;
            imem[word_addr[MEM_AW-1:0]] = prog[k].inst;
        end

        // nothing may retire while reset is held
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("write enable during reset", 32'(debug_wb_rf_wen), 32'h0);
            check_value("data SRAM request during reset", 32'(data_sram_en), 32'h0);
            check_value("data SRAM byte enables during reset", 32'(data_sram_wen), 32'h0);
            check_value("fetch request during reset", 32'(inst_sram_en), 32'h1);
            check_value("first fetch address", inst_sram_addr, RESET_PC);
        end
        rst = 1'b0;

        for (int k = 0; k < n_entries; k++) begin
            if (prog[k].we) begin
                do begin
                    @(negedge clk);
                end while (debug_wb_rf_wen === 4'h0);
                check_value("retired pc", debug_wb_pc, RESET_PC + 32'(4 * k));
                check_value("retired register", 32'(debug_wb_rf_wnum), 32'(prog[k].dest));
                check_value("retired data", debug_wb_rf_wdata, prog[k].value);
            end
        end

        // trailing nops must not write
        repeat (8) begin
            @(negedge clk);
            check_value("write after program end", 32'(debug_wb_rf_wen), 32'h0);
        end

        check_value("data SRAM write count", 32'(dmem_writes), 32'd1);
        check_value("data SRAM write address", last_wr_addr, DATA_ADDR);
        check_value("data SRAM byte enables", 32'(last_wr_wen), 32'h0000_000f);
        check_value("stored word", dmem[DATA_ADDR[MEM_AW+1:2]], 32'h1234_5678);

        if (u_mycpu_top.u_checker.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "run ended with failed checks");
        end
    end

    // stop early on a bound assertion failure
    initial begin
        wait (u_mycpu_top.u_checker.fail_count != 0);
        $display("a bound assertion on the core ports failed at t=%0t", $time);
        $display("** FAIL **");
        $fatal(1, "assertion failure");
    end

    // watchdog allows 40 cycles per program entry after reset
    initial begin
        repeat (RESET_CYCLES + 40 * N_ENTRIES) @(posedge clk);
        $display("watchdog expired: the program did not retire within %0d cycles",
                 RESET_CYCLES + 40 * N_ENTRIES);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: wb_stage.sv
`default_nettype none

module wb_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mem_valid,
    input  mycpu_pkg::mem_wb_t           mem_wb,
    output logic                         wb_allowin,
    output mycpu_pkg::rf_write_t         rf_wr,
    output mycpu_pkg::dest_t             wb_dest,
    output logic [mycpu_pkg::XLEN-1:0]   debug_wb_pc,
    output logic [3:0]                   debug_wb_rf_wen,
    output logic [mycpu_pkg::REG_AW-1:0] debug_wb_rf_wnum,
    output logic [mycpu_pkg::XLEN-1:0]   debug_wb_rf_wdata
);

    logic               wb_valid;
    mycpu_pkg::mem_wb_t mem_wb_r;

    // last stage, retires every cycle
    assign wb_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            mem_wb_r <= mem_wb;
        end
    end

    assign rf_wr   = '{we: wb_valid && mem_wb_r.rf_we, num: mem_wb_r.dest, data: mem_wb_r.wdata};
    assign wb_dest = '{we: rf_wr.we, num: mem_wb_r.dest};

    // debug port, write enable widened to byte lanes
    assign debug_wb_pc       = mem_wb_r.pc;
    assign debug_wb_rf_wen   = {4{rf_wr.we}};
    assign debug_wb_rf_wnum  = rf_wr.num;
    assign debug_wb_rf_wdata = rf_wr.data;

endmodule

`default_nettype wire
